/* src/regfile_pkg.sv */
// register file package with widths, opcodes and command/response structs
package regfile_pkg;

	localparam int WORD_W   = 32;
	localparam int DWORD_W  = 64;
	localparam int IDX_W    = 5;
	localparam int NUM_REGS = 32;
	localparam int PAIR_W   = IDX_W - 1; // fp pair index, idx without bit 0

	typedef logic [WORD_W-1:0]  word_t;
	typedef logic [DWORD_W-1:0] dword_t;
	typedef logic [IDX_W-1:0]   reg_idx_t;
	typedef logic [PAIR_W-1:0]  pair_idx_t;

	localparam reg_idx_t ZERO_REG  = 5'd0;
	localparam reg_idx_t FRAME_REG = 5'd30; // fp, bit 0 is the frame flag
	localparam reg_idx_t RA_REG    = 5'd31;

	typedef enum logic [2:0] {
		WR_NONE,
		WR_WORD,
		WR_BYTE,      // lb, zero-extended
		WR_JAL,       // return address into ra
		WR_FRAME,
		WR_HILO,      // mult/div result
		WR_FP_SINGLE,
		WR_FP_DOUBLE
	} wr_op_e;

	typedef enum logic [1:0] {
		RD_INT,
		RD_BYTE,      // sb, low byte of rt
		RD_FP,
		RD_STORE_FP   // base from int rs, value from fp pair rt
	} rd_op_e;

	typedef struct packed {
		wr_op_e   op;
		reg_idx_t idx;
		word_t    data;
		dword_t   data64;
	} wr_cmd_t;

	typedef struct packed {
		rd_op_e   op;
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t rd;
	} rd_cmd_t;

	// hi word of a double is the even register
	typedef struct packed {
		word_t rs_hi;
		word_t rs_lo;
		word_t rt_hi;
		word_t rt_lo;
		word_t rd_data;
		word_t hi;
		word_t lo;
	} rd_rsp_t;

	typedef struct packed {
		logic     en;
		reg_idx_t idx;
		word_t    data;
		logic     hilo_en;
		dword_t   hilo;
	} gpr_wr_t;

	typedef struct packed {
		logic      en;
		pair_idx_t pair;
		word_t     hi;
		word_t     lo;
	} fpr_wr_t;

endpackage

/* src/write_decode.sv */
// write decoder, maps a write command onto integer, hi/lo or fp bank requests
module write_decode import regfile_pkg::*; (
	input  wr_cmd_t wr_cmd_i,
	output gpr_wr_t gpr_wr_o,
	output fpr_wr_t fpr_wr_o
);

	logic int_ok; // target is not $zero
	logic fp_ok;  // fp target is even

	assign int_ok = (wr_cmd_i.idx != ZERO_REG);
	assign fp_ok  = ~wr_cmd_i.idx[0];

	always_comb begin
		gpr_wr_o = '0;
		fpr_wr_o = '0;

		case (wr_cmd_i.op)
			WR_WORD: begin
				gpr_wr_o.en   = int_ok;
				gpr_wr_o.idx  = wr_cmd_i.idx;
				gpr_wr_o.data = wr_cmd_i.data;
			end
			WR_BYTE: begin
				gpr_wr_o.en   = int_ok;
				gpr_wr_o.idx  = wr_cmd_i.idx;
				gpr_wr_o.data = {{(WORD_W-8){1'b0}}, wr_cmd_i.data[7:0]};
			end
			WR_JAL: begin
				gpr_wr_o.en   = 1'b1;
				gpr_wr_o.idx  = RA_REG; // idx field ignored
				gpr_wr_o.data = wr_cmd_i.data;
			end
			WR_FRAME: begin
				gpr_wr_o.en   = 1'b1;
				gpr_wr_o.idx  = FRAME_REG;
				gpr_wr_o.data = wr_cmd_i.data;
			end
			WR_HILO: begin
				gpr_wr_o.hilo_en = 1'b1;
				gpr_wr_o.hilo    = wr_cmd_i.data64; // hi is the upper word
			end
			WR_FP_SINGLE: begin
				fpr_wr_o.en   = fp_ok;
				fpr_wr_o.pair = wr_cmd_i.idx[IDX_W-1:1];
				fpr_wr_o.hi   = '0; // single lives in the odd (low) word
				fpr_wr_o.lo   = wr_cmd_i.data;
			end
			WR_FP_DOUBLE: begin
				fpr_wr_o.en   = fp_ok;
				fpr_wr_o.pair = wr_cmd_i.idx[IDX_W-1:1];
				fpr_wr_o.hi   = wr_cmd_i.data64[DWORD_W-1:WORD_W];
				fpr_wr_o.lo   = wr_cmd_i.data64[WORD_W-1:0];
			end
			default: ; // WR_NONE
		endcase
	end

endmodule

/* src/gpr_bank.sv */
// integer register bank with hi/lo and frame flag, three combinational read ports
module gpr_bank import regfile_pkg::*; (
	input  logic     Clk,
	input  logic     rst_n_i,
	input  gpr_wr_t  wr_i,
	input  reg_idx_t rs_idx_i,
	input  reg_idx_t rt_idx_i,
	input  reg_idx_t rd_idx_i,
	output word_t    rs_o,
	output word_t    rt_o,
	output word_t    rd_o,
	output word_t    hi_o,
	output word_t    lo_o,
	output logic     fp_flag_o
);

	word_t regs [NUM_REGS];
	word_t hi_q;
	word_t lo_q;

	always_ff @(posedge Clk) begin
		if (!rst_n_i) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
			hi_q <= '0;
			lo_q <= '0;
		end else begin
			if (wr_i.en) begin
				regs[wr_i.idx] <= wr_i.data;
			end
			if (wr_i.hilo_en) begin
				hi_q <= wr_i.hilo[DWORD_W-1:WORD_W];
				lo_q <= wr_i.hilo[WORD_W-1:0];
			end
		end
	end

	// $zero is hardwired on the read side
	assign rs_o = (rs_idx_i == ZERO_REG) ? '0 : regs[rs_idx_i];
	assign rt_o = (rt_idx_i == ZERO_REG) ? '0 : regs[rt_idx_i];
	assign rd_o = (rd_idx_i == ZERO_REG) ? '0 : regs[rd_idx_i];

	assign hi_o = hi_q;
	assign lo_o = lo_q;

	assign fp_flag_o = regs[FRAME_REG][0]; // follows the fp register directly

	// decode must have filtered $zero writes before they reach the bank
	a_no_zero_write: assert property (
		@(posedge Clk) disable iff (!rst_n_i)
		wr_i.en |-> (wr_i.idx != ZERO_REG)
	) else $error("integer write reached register 0");

	// decode issues either a word or a hi/lo write, never both
	a_one_gpr_write: assert property (
		@(posedge Clk) disable iff (!rst_n_i)
		!(wr_i.en && wr_i.hilo_en)
	) else $error("word and hi/lo write in the same cycle");

endmodule

/* src/fpr_bank.sv */
// floating-point register bank, 16 even/odd pairs read and written as doubles
module fpr_bank import regfile_pkg::*; (
	input  logic      Clk,
	input  logic      rst_n_i,
	input  fpr_wr_t   wr_i,
	input  pair_idx_t rs_pair_i,
	input  pair_idx_t rt_pair_i,
	output dword_t    rs_o,
	output dword_t    rt_o
);

	// big endian pairs, msw at the even index
	word_t fregs [NUM_REGS];

	reg_idx_t wr_even;
	reg_idx_t wr_odd;
	reg_idx_t rs_even;
	reg_idx_t rs_odd;
	reg_idx_t rt_even;
	reg_idx_t rt_odd;

	assign wr_even = {wr_i.pair, 1'b0};
	assign wr_odd  = {wr_i.pair, 1'b1};
	assign rs_even = {rs_pair_i, 1'b0};
	assign rs_odd  = {rs_pair_i, 1'b1};
	assign rt_even = {rt_pair_i, 1'b0};
	assign rt_odd  = {rt_pair_i, 1'b1};

	always_ff @(posedge Clk) begin
		if (!rst_n_i) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				fregs[i] <= '0;
			end
		end else if (wr_i.en) begin
			fregs[wr_even] <= wr_i.hi;
			fregs[wr_odd]  <= wr_i.lo;
		end
	end

	assign rs_o = {fregs[rs_even], fregs[rs_odd]};
	assign rt_o = {fregs[rt_even], fregs[rt_odd]};

	// a write issued while reset is held would be silently lost
	a_no_write_in_reset: assert property (
		@(posedge Clk)
		wr_i.en |-> rst_n_i
	) else $error("fp write presented during reset");

endmodule

/* src/read_stage.sv */
// read stage, picks int/fp/hi-lo sources by opcode and registers the response
module read_stage import regfile_pkg::*; (
	input  logic    Clk,
	input  logic    rst_n_i,
	input  rd_cmd_t rd_cmd_i,
	input  word_t   gpr_rs_i,
	input  word_t   gpr_rt_i,
	input  word_t   gpr_rd_i,
	input  word_t   hi_i,
	input  word_t   lo_i,
	input  dword_t  fpr_rs_i,
	input  dword_t  fpr_rt_i,
	output rd_rsp_t rsp_o
);

	rd_rsp_t rsp_d;
	rd_rsp_t rsp_q;

	logic rs_even;
	logic rt_even;

	assign rs_even = ~rd_cmd_i.rs[0];
	assign rt_even = ~rd_cmd_i.rt[0];

	always_comb begin
		rsp_d = rsp_q; // fields not selected by the op hold
		rsp_d.rd_data = gpr_rd_i;

		case (rd_cmd_i.op)
			RD_INT: begin
				rsp_d.rs_lo = gpr_rs_i;
				rsp_d.rt_lo = gpr_rt_i;
			end
			RD_BYTE: begin
				rsp_d.rs_lo = gpr_rs_i; // address base
				rsp_d.rt_lo = {{(WORD_W-8){1'b0}}, gpr_rt_i[7:0]};
			end
			RD_FP: begin
				if (rs_even) begin
					rsp_d.rs_hi = fpr_rs_i[DWORD_W-1:WORD_W];
					rsp_d.rs_lo = fpr_rs_i[WORD_W-1:0];
				end
				if (rt_even) begin
					rsp_d.rt_hi = fpr_rt_i[DWORD_W-1:WORD_W];
					rsp_d.rt_lo = fpr_rt_i[WORD_W-1:0];
				end
				rsp_d.hi = hi_i;
				rsp_d.lo = lo_i;
			end
			RD_STORE_FP: begin
				rsp_d.rs_lo = gpr_rs_i; // int base register
				if (rt_even) begin
					rsp_d.rt_hi = fpr_rt_i[DWORD_W-1:WORD_W];
					rsp_d.rt_lo = fpr_rt_i[WORD_W-1:0];
				end
			end
			default: ;
		endcase
	end

	always_ff @(posedge Clk) begin
		if (!rst_n_i) begin
			rsp_q <= '0;
		end else begin
			rsp_q <= rsp_d;
		end
	end

	assign rsp_o = rsp_q;

	// an X opcode would freeze or corrupt the held response fields
	a_op_known: assert property (
		@(posedge Clk) disable iff (!rst_n_i)
		!$isunknown(rd_cmd_i.op)
	) else $error("read opcode unknown");

endmodule

/* src/reg_file_top.sv */
// register file top, write decode into int/fp banks and a registered read stage
module reg_file_top import regfile_pkg::*; (
	input  logic    Clk,
	input  logic    rst_n_i,
	input  wr_cmd_t wr_cmd_i,
	input  rd_cmd_t rd_cmd_i,
	output rd_rsp_t rd_rsp_o,
	output logic    fp_flag_o
);

	gpr_wr_t gpr_wr;
	fpr_wr_t fpr_wr;

	word_t  gpr_rs;
	word_t  gpr_rt;
	word_t  gpr_rd;
	word_t  hi;
	word_t  lo;
	dword_t fpr_rs;
	dword_t fpr_rt;

	write_decode u_write_decode (
		.wr_cmd_i (wr_cmd_i),
		.gpr_wr_o (gpr_wr),
		.fpr_wr_o (fpr_wr)
	);

	gpr_bank u_gpr_bank (
		.Clk       (Clk),
		.rst_n_i   (rst_n_i),
		.wr_i      (gpr_wr),
		.rs_idx_i  (rd_cmd_i.rs),
		.rt_idx_i  (rd_cmd_i.rt),
		.rd_idx_i  (rd_cmd_i.rd),
		.rs_o      (gpr_rs),
		.rt_o      (gpr_rt),
		.rd_o      (gpr_rd),
		.hi_o      (hi),
		.lo_o      (lo),
		.fp_flag_o (fp_flag_o)
	);

	// pair index drops bit 0, odd reads are filtered in the read stage
	fpr_bank u_fpr_bank (
		.Clk       (Clk),
		.rst_n_i   (rst_n_i),
		.wr_i      (fpr_wr),
		.rs_pair_i (rd_cmd_i.rs[IDX_W-1:1]),
		.rt_pair_i (rd_cmd_i.rt[IDX_W-1:1]),
		.rs_o      (fpr_rs),
		.rt_o      (fpr_rt)
	);

	read_stage u_read_stage (
		.Clk      (Clk),
		.rst_n_i  (rst_n_i),
		.rd_cmd_i (rd_cmd_i),
		.gpr_rs_i (gpr_rs),
		.gpr_rt_i (gpr_rt),
		.gpr_rd_i (gpr_rd),
		.hi_i     (hi),
		.lo_i     (lo),
		.fpr_rs_i (fpr_rs),
		.fpr_rt_i (fpr_rt),
		.rsp_o    (rd_rsp_o)
	);

endmodule

/* include/tb_checks.svh */
// register file testbench compare tasks and error counters
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int unsigned err_cnt     = 0; // wrong values
int unsigned timeout_cnt = 0; // waits that never completed

task automatic check_word(input string what, input word_t got, input word_t exp);
	if (got !== exp) begin
		err_cnt++;
		$display("Error at %0t ns: %s is %08h, expected %08h", $time, what, got, exp);
	end
endtask

task automatic check_flag(input string what, input logic got, input logic exp);
	if (got !== exp) begin
		err_cnt++;
		$display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
	end
endtask

// field by field so a mismatch names the word that differs
task automatic check_rsp(input string what, input rd_rsp_t got, input rd_rsp_t exp);
	check_word({what, ".rs_hi"}, got.rs_hi, exp.rs_hi);
	check_word({what, ".rs_lo"}, got.rs_lo, exp.rs_lo);
	check_word({what, ".rt_hi"}, got.rt_hi, exp.rt_hi);
	check_word({what, ".rt_lo"}, got.rt_lo, exp.rt_lo);
	check_word({what, ".rd_data"}, got.rd_data, exp.rd_data);
	check_word({what, ".hi"}, got.hi, exp.hi);
	check_word({what, ".lo"}, got.lo, exp.lo);
endtask

task automatic report_timeout(input string what);
	timeout_cnt++;
	$display("Timed out at %0t ns while waiting for %s", $time, what);
endtask

`endif

/* tests/tb_reg_file.sv */
// register file testbench, directed write and read tests against a reference model
module tb_reg_file import regfile_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	logic    Clk;
	logic    rst_n_i;
	wr_cmd_t wr_cmd;
	rd_cmd_t rd_cmd;
	rd_rsp_t rd_rsp;
	logic    fp_flag;

	word_t   gpr_m [NUM_REGS]; // expected integer registers
	word_t   fpr_m [NUM_REGS]; // expected fp words, msw at even index
	word_t   hi_m;
	word_t   lo_m;
	rd_rsp_t exp_rsp;          // expected response, held fields included

	`include "tb_checks.svh"

	reg_file_top dut (
		.Clk       (Clk),
		.rst_n_i   (rst_n_i),
		.wr_cmd_i  (wr_cmd),
		.rd_cmd_i  (rd_cmd),
		.rd_rsp_o  (rd_rsp),
		.fp_flag_o (fp_flag)
	);

	initial begin
		Clk = 1'b0;
		forever #10 Clk = ~Clk;
	end

	function automatic wr_cmd_t write_cmd(input wr_op_e op, input int idx, input word_t data,
			input dword_t data64);
		wr_cmd_t c;
		c.op     = op;
		c.idx    = reg_idx_t'(idx);
		c.data   = data;
		c.data64 = data64;
		return c;
	endfunction

	function automatic rd_cmd_t read_cmd(input rd_op_e op, input int rs, input int rt,
			input int rd);
		rd_cmd_t c;
		c.op = op;
		c.rs = reg_idx_t'(rs);
		c.rt = reg_idx_t'(rt);
		c.rd = reg_idx_t'(rd);
		return c;
	endfunction

	function automatic wr_cmd_t no_write();
		return write_cmd(WR_NONE, 0, '0, '0);
	endfunction

	function automatic void clear_model();
		for (int i = 0; i < NUM_REGS; i++) begin
			gpr_m[i] = '0;
			fpr_m[i] = '0;
		end
		hi_m    = '0;
		lo_m    = '0;
		exp_rsp = '0;
	endfunction

	function automatic void model_write(input wr_cmd_t w);
		case (w.op)
			WR_WORD:  if (w.idx != 0) gpr_m[w.idx] = w.data;
			WR_BYTE:  if (w.idx != 0) gpr_m[w.idx] = {24'd0, w.data[7:0]};
			WR_JAL:   gpr_m[31] = w.data;
			WR_FRAME: gpr_m[30] = w.data;
			WR_HILO: begin
				hi_m = w.data64[63:32];
				lo_m = w.data64[31:0];
			end
			WR_FP_SINGLE: if (!w.idx[0]) begin
				fpr_m[w.idx]     = '0;
				fpr_m[w.idx + 1] = w.data;
			end
			WR_FP_DOUBLE: if (!w.idx[0]) begin
				fpr_m[w.idx]     = w.data64[63:32];
				fpr_m[w.idx + 1] = w.data64[31:0];
			end
			default: ;
		endcase
	endfunction

	// odd fp index leaves that side of the response as it was
	function automatic void predict_read(input rd_cmd_t r);
		exp_rsp.rd_data = gpr_m[r.rd];
		if (r.op == RD_FP && !r.rs[0]) begin
			exp_rsp.rs_hi = fpr_m[r.rs];
			exp_rsp.rs_lo = fpr_m[r.rs + 1];
		end
		if (r.op != RD_FP) exp_rsp.rs_lo = gpr_m[r.rs];
		if (r.op == RD_INT) exp_rsp.rt_lo = gpr_m[r.rt];
		if (r.op == RD_BYTE) exp_rsp.rt_lo = {24'd0, gpr_m[r.rt][7:0]};
		if ((r.op == RD_FP || r.op == RD_STORE_FP) && !r.rt[0]) begin
			exp_rsp.rt_hi = fpr_m[r.rt];
			exp_rsp.rt_lo = fpr_m[r.rt + 1];
		end
		if (r.op == RD_FP) begin
			exp_rsp.hi = hi_m;
			exp_rsp.lo = lo_m;
		end
	endfunction

	// one command, then an idle cycle, response checked one cycle after the read
	task automatic step(input wr_cmd_t w, input rd_cmd_t r);
		@(posedge Clk);
		wr_cmd <= w;
		rd_cmd <= r;
		predict_read(r); // no bypass, read sees the old state
		model_write(w);
		@(posedge Clk); // command sampled here
		wr_cmd <= no_write();
		rd_cmd <= read_cmd(RD_INT, 0, 0, 0);
		@(negedge Clk);
		check_rsp("rd_rsp", rd_rsp, exp_rsp);
		check_flag("fp_flag", fp_flag, gpr_m[30][0]);
		predict_read(read_cmd(RD_INT, 0, 0, 0)); // idle read at the next edge
	endtask

	task automatic wait_flag(input logic exp, input int limit);
		int n;
		n = 0;
		while (fp_flag !== exp && n < limit) begin
			@(negedge Clk);
			n++;
		end
		if (fp_flag !== exp) report_timeout("frame flag to change");
	endtask

	task automatic wait_reset_clear(input int limit);
		int n;
		n = 0;
		while ((rd_rsp !== '0 || fp_flag !== 1'b0) && n < limit) begin
			@(negedge Clk);
			n++;
		end
		if (rd_rsp !== '0 || fp_flag !== 1'b0) report_timeout("outputs to clear after reset");
	endtask

	task automatic apply_reset();
		@(posedge Clk);
		rst_n_i <= 1'b0;
		wr_cmd  <= no_write();
		rd_cmd  <= read_cmd(RD_INT, 0, 0, 0);
		repeat (5) @(posedge Clk);
		rst_n_i <= 1'b1;
		clear_model();
		wait_reset_clear(8);
	endtask

	task automatic test_word_rw();
		int idx_list [5] = '{1, 5, 9, 17, 23};
		foreach (idx_list[i]) begin
			step(write_cmd(WR_WORD, idx_list[i], $urandom(), '0), read_cmd(RD_INT, 0, 0, 0));
		end
		foreach (idx_list[i]) begin
			step(no_write(), read_cmd(RD_INT, idx_list[i], idx_list[i], idx_list[i]));
		end
		step(write_cmd(WR_WORD, 0, $urandom() | 32'h1, '0), read_cmd(RD_INT, 0, 0, 0));
		step(no_write(), read_cmd(RD_INT, 0, 5, 0));
		check_word("register 0", rd_rsp.rs_lo, '0);
	endtask

	task automatic test_byte_paths();
		step(write_cmd(WR_BYTE, 8, $urandom(), '0), read_cmd(RD_INT, 0, 0, 0));
		step(no_write(), read_cmd(RD_INT, 8, 8, 8));
		check_word("byte load upper bits", rd_rsp.rs_lo & 32'hffff_ff00, '0);
		step(write_cmd(WR_WORD, 9, $urandom(), '0), read_cmd(RD_INT, 0, 0, 0));
		step(no_write(), read_cmd(RD_BYTE, 9, 9, 9)); // rs full word, rt low byte
	endtask

	task automatic test_jal_frame();
		step(write_cmd(WR_JAL, 3, $urandom(), '0), read_cmd(RD_INT, 31, 3, 31));
		step(no_write(), read_cmd(RD_INT, 31, 3, 31));
		step(write_cmd(WR_FRAME, 0, $urandom() | 32'h1, '0), read_cmd(RD_INT, 0, 0, 0));
		wait_flag(1'b1, 4);
		check_flag("frame flag after odd write", fp_flag, 1'b1);
		step(write_cmd(WR_FRAME, 0, $urandom() & ~32'h1, '0), read_cmd(RD_INT, 30, 0, 30));
		wait_flag(1'b0, 4);
		check_flag("frame flag after even write", fp_flag, 1'b0);
	endtask

	task automatic test_hilo_fp();
		step(write_cmd(WR_HILO, 0, '0, {$urandom(), $urandom()}), read_cmd(RD_INT, 0, 0, 0));
		step(write_cmd(WR_FP_DOUBLE, 4, '0, {$urandom(), $urandom()}), read_cmd(RD_INT, 0, 0, 0));
		// pair 6/7 holds a double before the single overwrites it
		step(write_cmd(WR_FP_DOUBLE, 6, '0, {$urandom(), $urandom()}), read_cmd(RD_INT, 0, 0, 0));
		step(write_cmd(WR_FP_SINGLE, 6, $urandom(), '0), read_cmd(RD_INT, 0, 0, 0));
		step(no_write(), read_cmd(RD_FP, 4, 6, 1));
		check_word("single high word", rd_rsp.rt_hi, '0);
		// odd index, pair 4/5 must not change
		step(write_cmd(WR_FP_DOUBLE, 5, '0, {$urandom(), $urandom()}), read_cmd(RD_INT, 0, 0, 0));
		step(no_write(), read_cmd(RD_FP, 4, 4, 0));
		step(no_write(), read_cmd(RD_FP, 6, 5, 0)); // rt side holds
	endtask

	task automatic test_store_fp();
		step(write_cmd(WR_WORD, 12, $urandom(), '0), read_cmd(RD_INT, 0, 0, 0));
		step(write_cmd(WR_FP_DOUBLE, 10, '0, {$urandom(), $urandom()}), read_cmd(RD_INT, 0, 0, 0));
		step(no_write(), read_cmd(RD_STORE_FP, 12, 10, 12));
		step(no_write(), read_cmd(RD_STORE_FP, 5, 11, 9));
	endtask

	task automatic test_reset_same_edge();
		step(write_cmd(WR_WORD, 7, $urandom(), '0), read_cmd(RD_INT, 0, 0, 0));
		apply_reset();
		step(no_write(), read_cmd(RD_FP, 4, 6, 7));
		step(no_write(), read_cmd(RD_STORE_FP, 7, 10, 31));
		check_rsp("after reset", rd_rsp, '0);
		step(write_cmd(WR_WORD, 7, $urandom(), '0), read_cmd(RD_INT, 0, 0, 0));
		step(write_cmd(WR_WORD, 7, $urandom(), '0), read_cmd(RD_INT, 7, 7, 7)); // old value
		step(no_write(), read_cmd(RD_INT, 7, 7, 7));
	endtask

	initial begin
		void'($urandom(32'h667f_edd4));
		rst_n_i = 1'b0;
		wr_cmd  = no_write();
		rd_cmd  = read_cmd(RD_INT, 0, 0, 0);
		repeat (5) @(posedge Clk);
		rst_n_i <= 1'b1;
		clear_model();
		wait_reset_clear(8);

		test_word_rw();
		test_byte_paths();
		test_jal_frame();
		test_hilo_fp();
		test_store_fp();
		test_reset_same_edge();

		$display("value errors: %0d, timeouts: %0d", err_cnt, timeout_cnt);
		if (err_cnt == 0 && timeout_cnt == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

/* src.f */
+incdir+include
src/regfile_pkg.sv
src/write_decode.sv
src/gpr_bank.sv
src/fpr_bank.sv
src/read_stage.sv
src/reg_file_top.sv
tests/tb_reg_file.sv
